// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath word width
`define CPU_DATA_SIZE 32

// program counter width
`define CPU_PC_SIZE 10

// register index width
`define CPU_REG_ADDR_SIZE 5

// instruction memory words
`define CPU_IMEM_DEPTH 64

`endif

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef enum logic [5:0] {
    ALU_GRP = 6'b100000,
    MOVI    = 6'b100010,
    ADDI    = 6'b101000,
    XORI    = 6'b101011,
    ORI     = 6'b101100
  } opcode_t;

  // NOP is SRLI with a zero amount
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_op_t;

  typedef enum logic [1:0] {
    STOP  = 2'b00,
    FETCH = 2'b01,
    EXE   = 2'b10,
    WRITE = 2'b11
  } ctrl_state_t;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_t;

  // rb doubles as the shift amount in register-register form
  typedef struct packed {
    logic       spare;
    opcode_t    opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] gap;
    sub_op_t    sub_op;
  } r_fmt_t;

  typedef struct packed {
    logic        spare;
    opcode_t     opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm15;
  } i_fmt_t;

  typedef struct packed {
    logic        spare;
    opcode_t     opcode;
    logic [4:0]  rt;
    logic [19:0] imm20;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

`default_nettype wire

// File: source/ir_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module ir_controller (
  input  wire logic                              clock,
  input  wire logic                              reset,
  input  wire logic                              run,
  input  wire cpu_pkg::instr_t                   ir,
  output logic                                   reg_read,
  output logic                                   alu_execute,
  output logic                                   reg_write,
  output logic                                   pc_advance,
  output logic                                   halted,
  output cpu_pkg::opcode_t                       opcode,
  output cpu_pkg::sub_op_t                       sub_op,
  output logic [`CPU_REG_ADDR_SIZE-1:0]          ra,
  output logic [`CPU_REG_ADDR_SIZE-1:0]          rb,
  output logic [`CPU_REG_ADDR_SIZE-1:0]          rt,
  output cpu_pkg::instr_t                        imm_source,
  output cpu_pkg::imm_sel_t                      imm_select,
  output logic                                   imm_reg_select,
  output logic                                   writeback_select
);

  cpu_pkg::ctrl_state_t state;
  cpu_pkg::ctrl_state_t next_state;
  cpu_pkg::instr_t      present_instruction;
  logic                 is_shift;
  logic                 is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::STOP;
    end else begin
      state <= next_state;
    end
  end

  // only STOP waits on run so a started instruction always completes
  always_comb begin
    case (state)
      cpu_pkg::STOP:  next_state = run ? cpu_pkg::FETCH : cpu_pkg::STOP;
      cpu_pkg::FETCH: next_state = cpu_pkg::EXE;
      cpu_pkg::EXE:   next_state = cpu_pkg::WRITE;
      default:        next_state = cpu_pkg::STOP;
    endcase
  end

  // also loaded in STOP so the read addresses are settled during FETCH
  always_ff @(posedge clock) begin
    if (state == cpu_pkg::STOP || state == cpu_pkg::FETCH) begin
      present_instruction <= ir;
    end
  end

  assign opcode     = present_instruction.r_fmt.opcode;
  assign sub_op     = present_instruction.r_fmt.sub_op;
  assign rt         = present_instruction.r_fmt.rt;
  assign ra         = present_instruction.r_fmt.ra;
  assign rb         = present_instruction.r_fmt.rb;
  assign imm_source = present_instruction;

  assign is_shift = (opcode == cpu_pkg::ALU_GRP) &&
                    (sub_op inside {cpu_pkg::SLLI, cpu_pkg::SRLI, cpu_pkg::ROTRI});
  assign is_nop   = (opcode == cpu_pkg::ALU_GRP) && (sub_op == cpu_pkg::SRLI) && (rb == '0);

  assign reg_read    = (state == cpu_pkg::FETCH);
  assign alu_execute = (state == cpu_pkg::EXE);
  assign reg_write   = (state == cpu_pkg::WRITE) && !is_nop;
  assign pc_advance  = (state == cpu_pkg::WRITE);
  assign halted      = (state == cpu_pkg::STOP) && !run;

  // MOVI bypasses the alu
  assign writeback_select = (opcode == cpu_pkg::MOVI);

  always_comb begin
    case (opcode)
      cpu_pkg::ADDI:                imm_select = cpu_pkg::IMM15_SE;
      cpu_pkg::ORI, cpu_pkg::XORI:  imm_select = cpu_pkg::IMM15_ZE;
      cpu_pkg::MOVI:                imm_select = cpu_pkg::IMM20_SE;
      default:                      imm_select = cpu_pkg::IMM5_ZE;
    endcase
    imm_reg_select = is_shift || (opcode != cpu_pkg::ALU_GRP);
  end

endmodule

`default_nettype wire

// File: source/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module instr_fetch (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire logic                                load_we,
  input  wire logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  load_addr,
  input  wire logic [`CPU_DATA_SIZE-1:0]           load_data,
  input  wire logic                                pc_advance,
  output logic [`CPU_PC_SIZE-1:0]                  pc,
  output cpu_pkg::instr_t                          ir
);

  localparam int unsigned IMEM_ADDR_SIZE = $clog2(`CPU_IMEM_DEPTH);

  logic [`CPU_DATA_SIZE-1:0] imem [`CPU_IMEM_DEPTH];

  always_ff @(posedge clock) begin
    if (load_we) begin
      imem[load_addr] <= load_data;
    end
  end

  // pc wraps within the memory
  assign ir = imem[pc[IMEM_ADDR_SIZE-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_advance) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module register_file (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          reg_read,
  input  wire logic [`CPU_REG_ADDR_SIZE-1:0] read_address1,
  input  wire logic [`CPU_REG_ADDR_SIZE-1:0] read_address2,
  input  wire logic                          reg_write,
  input  wire logic [`CPU_REG_ADDR_SIZE-1:0] write_address,
  input  wire logic [`CPU_DATA_SIZE-1:0]     write_data,
  output logic [`CPU_DATA_SIZE-1:0]          src1,
  output logic [`CPU_DATA_SIZE-1:0]          src2
);

  localparam int unsigned NUM_REGS = 1 << `CPU_REG_ADDR_SIZE;

  logic [`CPU_DATA_SIZE-1:0] regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[write_address] <= write_data;
    end
  end

  // read ports sampled once per instruction
  always_ff @(posedge clock) begin
    if (reset) begin
      src1 <= '0;
      src2 <= '0;
    end else if (reg_read) begin
      src1 <= regs[read_address1];
      src2 <= regs[read_address2];
    end
  end

endmodule

`default_nettype wire

// File: source/operand_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module operand_select (
  input  wire cpu_pkg::instr_t           imm_source,
  input  wire cpu_pkg::imm_sel_t         imm_select,
  input  wire logic                      imm_reg_select,
  input  wire logic                      writeback_select,
  input  wire logic [`CPU_DATA_SIZE-1:0] src2,
  input  wire logic [`CPU_DATA_SIZE-1:0] alu_result,
  output logic [`CPU_DATA_SIZE-1:0]      operand_b,
  output logic [`CPU_DATA_SIZE-1:0]      writeback_data
);

  logic [`CPU_DATA_SIZE-1:0] imm_ext;

  always_comb begin
    case (imm_select)
      cpu_pkg::IMM15_SE: begin
        imm_ext = {{(`CPU_DATA_SIZE-15){imm_source.i_fmt.imm15[14]}}, imm_source.i_fmt.imm15};
      end
      cpu_pkg::IMM15_ZE: begin
        imm_ext = {{(`CPU_DATA_SIZE-15){1'b0}}, imm_source.i_fmt.imm15};
      end
      cpu_pkg::IMM20_SE: begin
        imm_ext = {{(`CPU_DATA_SIZE-20){imm_source.j_fmt.imm20[19]}}, imm_source.j_fmt.imm20};
      end
      // shift amount sits in the rb field
      default: begin
        imm_ext = {{(`CPU_DATA_SIZE-5){1'b0}}, imm_source.r_fmt.rb};
      end
    endcase
  end

  assign operand_b      = imm_reg_select ? imm_ext : src2;
  assign writeback_data = writeback_select ? operand_b : alu_result;

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module alu (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire logic                      alu_execute,
  input  wire cpu_pkg::opcode_t          opcode,
  input  wire cpu_pkg::sub_op_t          sub_op,
  input  wire logic [`CPU_DATA_SIZE-1:0] src1,
  input  wire logic [`CPU_DATA_SIZE-1:0] operand_b,
  output logic [`CPU_DATA_SIZE-1:0]      alu_result
);

  logic [4:0]                  shamt;
  logic [2*`CPU_DATA_SIZE-1:0] rot_wide;
  logic [`CPU_DATA_SIZE-1:0]   result_next;

  assign shamt    = operand_b[4:0];
  // rotate by shifting a doubled word
  assign rot_wide = {src1, src1} >> shamt;

  always_comb begin
    case (opcode)
      cpu_pkg::ALU_GRP: begin
        case (sub_op)
          cpu_pkg::ADD:   result_next = src1 + operand_b;
          cpu_pkg::SUB:   result_next = src1 - operand_b;
          cpu_pkg::AND:   result_next = src1 & operand_b;
          cpu_pkg::OR:    result_next = src1 | operand_b;
          cpu_pkg::XOR:   result_next = src1 ^ operand_b;
          cpu_pkg::SLLI:  result_next = src1 << shamt;
          cpu_pkg::SRLI:  result_next = src1 >> shamt;
          cpu_pkg::ROTRI: result_next = rot_wide[`CPU_DATA_SIZE-1:0];
          default:        result_next = '0;
        endcase
      end
      cpu_pkg::ADDI: result_next = src1 + operand_b;
      cpu_pkg::ORI:  result_next = src1 | operand_b;
      cpu_pkg::XORI: result_next = src1 ^ operand_b;
      default:       result_next = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (alu_execute) begin
      alu_result <= result_next;
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_top (
  input  wire logic                               clock,
  input  wire logic                               reset,
  input  wire logic                               run,
  input  wire logic                               load_we,
  input  wire logic [$clog2(`CPU_IMEM_DEPTH)-1:0] load_addr,
  input  wire logic [`CPU_DATA_SIZE-1:0]          load_data,
  output logic [`CPU_PC_SIZE-1:0]                 pc,
  output logic                                    retire,
  output logic [`CPU_REG_ADDR_SIZE-1:0]           retire_addr,
  output logic [`CPU_DATA_SIZE-1:0]               retire_data,
  output logic                                    halted
);

  cpu_pkg::instr_t                ir;
  cpu_pkg::instr_t                imm_source;
  cpu_pkg::opcode_t               opcode;
  cpu_pkg::sub_op_t               sub_op;
  cpu_pkg::imm_sel_t              imm_select;
  logic                           reg_read;
  logic                           alu_execute;
  logic                           reg_write;
  logic                           pc_advance;
  logic                           imm_reg_select;
  logic                           writeback_select;
  logic [`CPU_REG_ADDR_SIZE-1:0]  ra;
  logic [`CPU_REG_ADDR_SIZE-1:0]  rb;
  logic [`CPU_REG_ADDR_SIZE-1:0]  rt;
  logic [`CPU_DATA_SIZE-1:0]      src1;
  logic [`CPU_DATA_SIZE-1:0]      src2;
  logic [`CPU_DATA_SIZE-1:0]      operand_b;
  logic [`CPU_DATA_SIZE-1:0]      alu_result;
  logic [`CPU_DATA_SIZE-1:0]      writeback_data;

  instr_fetch u_fetch (
    .clock, .reset, .load_we, .load_addr, .load_data, .pc_advance, .pc, .ir
  );

  ir_controller u_ctrl (
    .clock, .reset, .run, .ir, .reg_read, .alu_execute, .reg_write, .pc_advance,
    .halted, .opcode, .sub_op, .ra, .rb, .rt, .imm_source, .imm_select,
    .imm_reg_select, .writeback_select
  );

  register_file u_regs (
    .clock, .reset, .reg_read, .read_address1(ra), .read_address2(rb),
    .reg_write, .write_address(rt), .write_data(writeback_data), .src1, .src2
  );

  operand_select u_opsel (
    .imm_source, .imm_select, .imm_reg_select, .writeback_select, .src2,
    .alu_result, .operand_b, .writeback_data
  );

  alu u_alu (
    .clock, .reset, .alu_execute, .opcode, .sub_op, .src1, .operand_b, .alu_result
  );

  // every register write retires an instruction
  assign retire      = reg_write;
  assign retire_addr = rt;
  assign retire_data = writeback_data;

endmodule

`default_nettype wire

// File: tb/cpu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_sva (
  input wire logic                 clock,
  input wire logic                 reset,
  input wire cpu_pkg::ctrl_state_t state,
  input wire logic                 reg_read,
  input wire logic                 alu_execute,
  input wire logic                 reg_write,
  input wire logic                 pc_advance
);

  a_stop_next: assert property (@(posedge clock) disable iff (reset)
    (state == cpu_pkg::STOP) |=> (state == cpu_pkg::STOP || state == cpu_pkg::FETCH))
    else $error("STOP left for a state other than FETCH");

  a_fetch_exe: assert property (@(posedge clock) disable iff (reset)
    (state == cpu_pkg::FETCH) |=> (state == cpu_pkg::EXE))
    else $error("FETCH not followed by EXE");

  a_exe_write: assert property (@(posedge clock) disable iff (reset)
    (state == cpu_pkg::EXE) |=> (state == cpu_pkg::WRITE))
    else $error("EXE not followed by WRITE");

  a_write_stop: assert property (@(posedge clock) disable iff (reset)
    (state == cpu_pkg::WRITE) |=> (state == cpu_pkg::STOP))
    else $error("WRITE not followed by STOP");

  a_write_state: assert property (@(posedge clock) disable iff (reset)
    reg_write |-> (state == cpu_pkg::WRITE))
    else $error("reg_write outside WRITE");

  a_one_enable: assert property (@(posedge clock) disable iff (reset)
    $onehot0({reg_read, alu_execute, reg_write}))
    else $error("more than one enable high");

  // enables quiet in the cycle after reset
  a_reset_idle: assert property (@(posedge clock)
    reset |=> !(reg_read || alu_execute || reg_write || pc_advance))
    else $error("enable high after reset");

endmodule

bind ir_controller cpu_sva u_sva (
  .clock, .reset, .state, .reg_read, .alu_execute, .reg_write, .pc_advance
);

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

  localparam int NUM_INSTR      = 48;
  localparam int FIRST_PART     = 32;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 100;
  localparam int IMEM_ADDR_SIZE = $clog2(`CPU_IMEM_DEPTH);

  logic                          clock;
  logic                          reset;
  logic                          run;
  logic                          load_we;
  logic [IMEM_ADDR_SIZE-1:0]     load_addr;
  logic [`CPU_DATA_SIZE-1:0]     load_data;
  logic [`CPU_PC_SIZE-1:0]       pc;
  logic                          retire;
  logic [`CPU_REG_ADDR_SIZE-1:0] retire_addr;
  logic [`CPU_DATA_SIZE-1:0]     retire_data;
  logic                          halted;

  cpu_pkg::instr_t               program_mem [NUM_INSTR];
  logic [`CPU_DATA_SIZE-1:0]     model_regs [1 << `CPU_REG_ADDR_SIZE];
  logic [`CPU_REG_ADDR_SIZE-1:0] exp_addr_q [$];
  logic [`CPU_DATA_SIZE-1:0]     exp_data_q [$];
  string                         exp_name_q [$];
  logic [31:0]                   lcg_state;
  int                            retire_count;
  int                            expected_retires;
  int                            value_errors;
  int                            other_errors;
  int                            cycles;

  cpu_top uut (
    .clock, .reset, .run, .load_we, .load_addr, .load_data, .pc, .retire,
    .retire_addr, .retire_data, .halted
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic bit is_nop(input cpu_pkg::instr_t w);
    return w.r_fmt.opcode == cpu_pkg::ALU_GRP && w.r_fmt.sub_op == cpu_pkg::SRLI &&
           w.r_fmt.rb == '0;
  endfunction

  function automatic string mnemonic(input cpu_pkg::instr_t w);
    if (w.r_fmt.opcode == cpu_pkg::ALU_GRP) begin
      return w.r_fmt.sub_op.name();
    end
    return w.r_fmt.opcode.name();
  endfunction

  // ISA rules applied to the model registers
  function automatic logic [`CPU_DATA_SIZE-1:0] model_result(input cpu_pkg::instr_t w);
    logic [`CPU_DATA_SIZE-1:0] a;
    logic [`CPU_DATA_SIZE-1:0] b;
    logic [4:0]                amt;
    logic [`CPU_DATA_SIZE-1:0] result;
    a      = model_regs[w.r_fmt.ra];
    b      = model_regs[w.r_fmt.rb];
    amt    = w.r_fmt.rb;
    result = '0;
    case (w.r_fmt.opcode)
      cpu_pkg::ALU_GRP: begin
        case (w.r_fmt.sub_op)
          cpu_pkg::ADD:   result = a + b;
          cpu_pkg::SUB:   result = a - b;
          cpu_pkg::AND:   result = a & b;
          cpu_pkg::OR:    result = a | b;
          cpu_pkg::XOR:   result = a ^ b;
          cpu_pkg::SLLI:  result = a << amt;
          cpu_pkg::SRLI:  result = a >> amt;
          cpu_pkg::ROTRI: result = (a >> amt) | (a << (`CPU_DATA_SIZE - int'(amt)));
          default:        result = '0;
        endcase
      end
      cpu_pkg::ADDI: result = a + `CPU_DATA_SIZE'($signed(w.i_fmt.imm15));
      cpu_pkg::ORI:  result = a | `CPU_DATA_SIZE'(w.i_fmt.imm15);
      cpu_pkg::XORI: result = a ^ `CPU_DATA_SIZE'(w.i_fmt.imm15);
      cpu_pkg::MOVI: result = `CPU_DATA_SIZE'($signed(w.j_fmt.imm20));
      default:       result = '0;
    endcase
    return result;
  endfunction

  task automatic build_program();
    cpu_pkg::instr_t w;
    logic [31:0]     sel;
    int              pick;
    for (int i = 0; i < NUM_INSTR; i++) begin
      w    = next_random();
      sel  = next_random();
      pick = int'(sel[31:16]) % 5;
      case (pick)
        0:       w.r_fmt.opcode = cpu_pkg::ADDI;
        1:       w.r_fmt.opcode = cpu_pkg::ORI;
        2:       w.r_fmt.opcode = cpu_pkg::XORI;
        3:       w.r_fmt.opcode = cpu_pkg::MOVI;
        default: w.r_fmt.opcode = cpu_pkg::ALU_GRP;
      endcase
      case (sel[10:8])
        3'd0:    w.r_fmt.sub_op = cpu_pkg::ADD;
        3'd1:    w.r_fmt.sub_op = cpu_pkg::SUB;
        3'd2:    w.r_fmt.sub_op = cpu_pkg::AND;
        3'd3:    w.r_fmt.sub_op = cpu_pkg::OR;
        3'd4:    w.r_fmt.sub_op = cpu_pkg::XOR;
        3'd5:    w.r_fmt.sub_op = cpu_pkg::SLLI;
        3'd6:    w.r_fmt.sub_op = cpu_pkg::SRLI;
        default: w.r_fmt.sub_op = cpu_pkg::ROTRI;
      endcase
      // every sixth slot is a NOP
      if (i % 6 == 5) begin
        w.r_fmt.opcode = cpu_pkg::ALU_GRP;
        w.r_fmt.sub_op = cpu_pkg::SRLI;
        w.r_fmt.rb     = '0;
      end
      program_mem[i] = w;
    end
  endtask

  task automatic check_word(input string name, input logic [`CPU_DATA_SIZE-1:0] expected,
                            input logic [`CPU_DATA_SIZE-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_reg_addr(input string name,
                                input logic [`CPU_REG_ADDR_SIZE-1:0] expected,
                                input logic [`CPU_REG_ADDR_SIZE-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // load, predict and execute program slots first..last-1
  task automatic run_segment(input int first, input int last);
    cpu_pkg::instr_t w;
    if (!halted) begin
      other_errors++;
      $display("core is not halted before loading slot %0d", first);
    end
    for (int i = first; i < last; i++) begin
      @(posedge clock);
      #2;
      load_we   = 1'b1;
      load_addr = IMEM_ADDR_SIZE'(i);
      load_data = program_mem[i];
      w         = program_mem[i];
      if (!is_nop(w)) begin
        exp_addr_q.push_back(w.r_fmt.rt);
        exp_data_q.push_back(model_result(w));
        exp_name_q.push_back($sformatf("%s@%0d", mnemonic(w), i));
        model_regs[w.r_fmt.rt] = model_result(w);
        expected_retires++;
      end
    end
    @(posedge clock);
    #2;
    load_we = 1'b0;
    run     = 1'b1;
    while (pc != `CPU_PC_SIZE'(last)) begin
      @(posedge clock);
      #2;
    end
    run = 1'b0;
    @(posedge clock);
    #2;
    if (!halted) begin
      other_errors++;
      $display("core did not halt after run dropped at pc %0d", pc);
    end
    repeat (3) @(posedge clock);
    #2;
    check_word("pc_after_halt", `CPU_DATA_SIZE'(last), `CPU_DATA_SIZE'(pc));
    check_word("retire_count", `CPU_DATA_SIZE'(expected_retires), `CPU_DATA_SIZE'(retire_count));
    if (exp_addr_q.size() != 0) begin
      other_errors++;
      $display("%0d expected retires never appeared", exp_addr_q.size());
    end
  endtask

  always @(negedge clock) begin
    if (retire) begin
      retire_count++;
      if (exp_addr_q.size() == 0) begin
        other_errors++;
        $display("unexpected retire to r%0d", retire_addr);
      end else begin
        check_reg_addr({exp_name_q[0], " addr"}, exp_addr_q.pop_front(), retire_addr);
        check_word({exp_name_q.pop_front(), " data"}, exp_data_q.pop_front(), retire_data);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout after %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset            = 1'b1;
    run              = 1'b0;
    load_we          = 1'b0;
    load_addr        = '0;
    load_data        = '0;
    lcg_state        = 32'd82;
    retire_count     = 0;
    expected_retires = 0;
    value_errors     = 0;
    other_errors     = 0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    build_program();
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    run_segment(0, FIRST_PART);
    // second load continues from the halted pc and register state
    run_segment(FIRST_PART, NUM_INSTR);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/cpu_pkg.sv
source/ir_controller.sv
source/instr_fetch.sv
source/register_file.sv
source/operand_select.sv
source/alu.sv
source/cpu_top.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
